// ==== logic/harness_pkg.sv ====
// -------------------------------------------------------------------------
// Shared widths, memory map and boot image of the SoC test harness.
// Imported by every RTL block and read by the testbench for its
// ROM and exit-code model.
// -------------------------------------------------------------------------

package harness_pkg;

  // -------------------------------------------------------------------------
  // Bus widths
  // -------------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

  // -------------------------------------------------------------------------
  // Memory map
  // -------------------------------------------------------------------------
  localparam addr_t       RomBase  = 32'h0001_0000;
  localparam int unsigned RomWords = 8;

  // Fixed boot code, one 64-bit word per entry
  localparam data_t BootImage [RomWords] = '{
    64'h0000_0513_0000_0297,
    64'h0182_b283_0105_0593,
    64'h0002_8067_f140_2573,
    64'h1050_0073_0000_0013,
    64'hffdf_f06f_0000_0013,
    64'h0000_0000_8000_0000,
    64'hdead_beef_cafe_f00d,
    64'h0123_4567_89ab_cdef
  };

  localparam addr_t SramBase = 32'h8000_0000;
  localparam addr_t ExitAddr = SramBase + 32'h0000_0100;  // Also a normal SRAM word

  // Decoded target of a bus request
  typedef enum logic [1:0] {
    REGION_ROM,
    REGION_SRAM,
    REGION_ERR
  } region_e;

  // Top level defaults
  localparam int unsigned DefaultNumWords       = 1024;
  localparam int unsigned DefaultDbgDelayCycles = 500;
  localparam int unsigned DefaultNrHarts        = 2;

endpackage

// ==== logic/bus_demux.sv ====
// -------------------------------------------------------------------------
// Address demultiplexer of the harness memory bus. Decodes each request
// to ROM, SRAM or error, raises the matching select strobe and answers
// every request exactly one cycle later.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module bus_demux #(
  parameter int unsigned NumWords = harness_pkg::DefaultNumWords
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::data_t rom_rdata_i,
  input  harness_pkg::data_t sram_rdata_i,
  output logic               rom_req_o,
  output logic               sram_req_o,
  output logic               rvalid_o,
  output logic               err_o,
  output harness_pkg::data_t rdata_o
);

  import harness_pkg::*;

  localparam addr_t RomEnd  = RomBase + addr_t'(RomWords * StrbWidth);
  localparam addr_t SramEnd = SramBase + addr_t'(NumWords * StrbWidth);

  region_e region;
  logic    err;
  region_e rsel_q;    // Source of read data for the response in flight
  logic    rvalid_q;
  logic    err_q;

  // -------------------------------------------------------------------------
  // Decode
  // -------------------------------------------------------------------------
  always_comb begin
    if (addr_i >= RomBase && addr_i < RomEnd) begin
      region = REGION_ROM;
    end else if (addr_i >= SramBase && addr_i < SramEnd) begin
      region = REGION_SRAM;
    end else begin
      region = REGION_ERR;
    end
  end

  // ROM is read only
  assign err = (region == REGION_ERR) || (region == REGION_ROM && we_i);

  assign rom_req_o  = req_i && (region == REGION_ROM) && !we_i;
  assign sram_req_o = req_i && (region == REGION_SRAM);

  // -------------------------------------------------------------------------
  // Response stage
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rsel_q   <= REGION_ERR;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i && err;
      // Writes, errors and idle cycles return zero data
      rsel_q   <= (req_i && !we_i && !err) ? region : REGION_ERR;
    end
  end

  always_comb begin
    case (rsel_q)
      REGION_ROM:  rdata_o = rom_rdata_i;
      REGION_SRAM: rdata_o = sram_rdata_i;
      default:     rdata_o = '0;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(rom_req_o && sram_req_o));

endmodule

// ==== logic/boot_rom.sv ====
// -------------------------------------------------------------------------
// Read-only boot memory holding the fixed boot image. Read data is
// registered on a request and held otherwise.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module boot_rom (
  input  logic               clk_i,
  input  logic               req_i,
  input  harness_pkg::addr_t addr_i,
  output harness_pkg::data_t rdata_o
);

  import harness_pkg::*;

  localparam int unsigned OffWidth = $clog2(StrbWidth);
  localparam int unsigned IdxWidth = $clog2(RomWords);

  logic [IdxWidth-1:0] word_idx;
  data_t               rdata_q;

  // Upper address bits wrap around the image
  assign word_idx = addr_i[OffWidth +: IdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= BootImage[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== logic/data_sram.sv ====
// -------------------------------------------------------------------------
// Word-addressed data memory with per-byte write enables. Reads
// register the full word one cycle after the request.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module data_sram #(
  parameter int unsigned NumWords = harness_pkg::DefaultNumWords
) (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  output harness_pkg::data_t rdata_o
);

  import harness_pkg::*;

  localparam int unsigned OffWidth = $clog2(StrbWidth);
  localparam int unsigned IdxWidth = $clog2(NumWords);

  data_t               mem_q [NumWords];
  data_t               rdata_q;
  logic [IdxWidth-1:0] word_idx;
  addr_t               sram_off;  // Byte offset into the region

  assign word_idx = addr_i[OffWidth +: IdxWidth];
  assign sram_off = addr_i - SramBase;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned i = 0; i < StrbWidth; i++) begin
          if (be_i[i]) begin
            mem_q[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rdata_o = rdata_q;

  // The decoder upstream must keep requests inside the array
  a_idx_in_range: assert property (@(posedge clk_i)
    req_i |-> (sram_off[AddrWidth-1:OffWidth] < NumWords));

endmodule

// ==== logic/exit_monitor.sv ====
// -------------------------------------------------------------------------
// Captures the program's exit code. The first SRAM write to the exit
// address is latched and flagged valid until the next reset.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module exit_monitor (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::data_t wdata_i,
  output harness_pkg::data_t exit_o,
  output logic               exit_valid_o
);

  import harness_pkg::*;

  logic  exit_hit;
  logic  done_q;   // Sticky, code already captured
  data_t code_q;

  assign exit_hit = req_i && we_i && (addr_i == ExitAddr);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
      code_q <= '0;
    end else if (exit_hit && !done_q) begin
      done_q <= 1'b1;
      code_q <= wdata_i;
    end
  end

  assign exit_o       = code_q;
  assign exit_valid_o = done_q;

  a_exit_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exit_valid_o |=> exit_valid_o && $stable(exit_o));

endmodule

// ==== logic/debug_req_gate.sv ====
// -------------------------------------------------------------------------
// Per-hart debug request gate. Requests are held back for a fixed
// number of cycles after reset and whenever debug is disabled.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module debug_req_gate #(
  parameter int unsigned DbgDelayCycles = harness_pkg::DefaultDbgDelayCycles,
  parameter int unsigned NrHarts        = harness_pkg::DefaultNrHarts
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               debug_enable_i,
  input  logic [NrHarts-1:0] debug_req_i,
  output logic [NrHarts-1:0] debug_req_o
);

  localparam int unsigned CntWidth =
    (DbgDelayCycles > 0) ? $clog2(DbgDelayCycles + 1) : 1;

  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] cnt_q;

  // Count down once, then rest at zero
  assign cnt_d = (cnt_q != '0) ? cnt_q - 1'b1 : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntWidth'(DbgDelayCycles);
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign debug_req_o = (cnt_q != '0 || !debug_enable_i) ? '0 : debug_req_i;

  a_quiet_in_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q != '0) |-> (debug_req_o == '0));

endmodule

// ==== logic/soc_harness.sv ====
// -------------------------------------------------------------------------
// Top level of the SoC test harness. Connects the single bus master
// port to boot ROM and data SRAM through the demux, watches for the
// exit code and gates the per-hart debug requests.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module soc_harness #(
  parameter int unsigned NumWords       = harness_pkg::DefaultNumWords,
  parameter int unsigned DbgDelayCycles = harness_pkg::DefaultDbgDelayCycles,
  parameter int unsigned NrHarts        = harness_pkg::DefaultNrHarts
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Memory bus master port
  input  logic               req_i,
  input  logic               we_i,
  input  harness_pkg::addr_t addr_i,
  input  harness_pkg::strb_t be_i,
  input  harness_pkg::data_t wdata_i,
  output logic               rvalid_o,
  output harness_pkg::data_t rdata_o,
  output logic               err_o,
  // Exit code
  output harness_pkg::data_t exit_o,
  output logic               exit_valid_o,
  // Debug
  input  logic               debug_enable_i,
  input  logic [NrHarts-1:0] debug_req_i,
  output logic [NrHarts-1:0] debug_req_o
);

  import harness_pkg::*;

  logic  rom_req;
  logic  sram_req;
  data_t rom_rdata;
  data_t sram_rdata;

  // -------------------------------------------------------------------------
  // Bus and memories
  // -------------------------------------------------------------------------
  bus_demux #(
    .NumWords     ( NumWords     )
  ) i_bus_demux (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .rom_rdata_i  ( rom_rdata    ),
    .sram_rdata_i ( sram_rdata   ),
    .rom_req_o    ( rom_req      ),
    .sram_req_o   ( sram_req     ),
    .rvalid_o     ( rvalid_o     ),
    .err_o        ( err_o        ),
    .rdata_o      ( rdata_o      )
  );

  boot_rom i_boot_rom (
    .clk_i   ( clk_i     ),
    .req_i   ( rom_req   ),
    .addr_i  ( addr_i    ),
    .rdata_o ( rom_rdata )
  );

  data_sram #(
    .NumWords ( NumWords   )
  ) i_data_sram (
    .clk_i    ( clk_i      ),
    .req_i    ( sram_req   ),
    .we_i     ( we_i       ),
    .addr_i   ( addr_i     ),
    .be_i     ( be_i       ),
    .wdata_i  ( wdata_i    ),
    .rdata_o  ( sram_rdata )
  );

  // -------------------------------------------------------------------------
  // Exit code and debug gating
  // -------------------------------------------------------------------------
  exit_monitor i_exit_monitor (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .req_i        ( sram_req     ),  // Only in-range SRAM accesses count
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .wdata_i      ( wdata_i      ),
    .exit_o       ( exit_o       ),
    .exit_valid_o ( exit_valid_o )
  );

  debug_req_gate #(
    .DbgDelayCycles ( DbgDelayCycles ),
    .NrHarts        ( NrHarts        )
  ) i_debug_req_gate (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .debug_enable_i ( debug_enable_i ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// ==== dv/tb_soc_harness.sv ====
// -------------------------------------------------------------------------
// Testbench of the SoC test harness. Drives random bus traffic and debug
// requests into the top level and checks every response against a model
// of ROM, SRAM, exit code and debug gating.
// -------------------------------------------------------------------------

`timescale 1ns/100ps

module tb_soc_harness;

  import harness_pkg::*;

  localparam int unsigned NumWords       = 1024;
  localparam int unsigned DbgDelayCycles = 40;
  localparam int unsigned NrHarts        = 2;
  localparam logic [31:0] Seed           = 32'h3953c69a;

  // Cycles spent in each test phase
  localparam int unsigned PoolWords = 32;
  localparam int unsigned RomReads  = 40;
  localparam int unsigned SramOps   = 300;
  localparam int unsigned ErrOps    = 60;
  localparam int unsigned ExitOps   = 6;
  localparam int unsigned NumTxn    =
    RomReads + 2 * PoolWords + SramOps + ErrOps + RomWords + ExitOps + 2;
  localparam longint unsigned TimeoutNs = (NumTxn + 4 * DbgDelayCycles + 100) * 4;

  logic               clk_i = 1'b0;
  logic               rst_ni;
  logic               req;
  logic               we;
  addr_t              addr;
  strb_t              be;
  data_t              wdata;
  logic               dbg_en;
  logic [NrHarts-1:0] dbg_req;
  logic               rvalid;
  data_t              rdata;
  logic               err;
  data_t              exit_code;
  logic               exit_valid;
  logic [NrHarts-1:0] dbg_req_gated;

  // Reference model state
  data_t       sram_model [NumWords];
  bit          word_known [NumWords];  // All bytes written at least once
  logic        exp_valid;              // Response expected on next edge
  logic        exp_err;
  data_t       exp_rdata;
  logic        exp_cmp;
  logic        exp_exit_valid;
  data_t       exp_exit;
  int unsigned cyc;                    // Rising edges since reset release
  int unsigned errors = 0;
  logic [31:0] rng_state;

  always #2 clk_i = ~clk_i;

  soc_harness #(
    .NumWords       ( NumWords       ),
    .DbgDelayCycles ( DbgDelayCycles ),
    .NrHarts        ( NrHarts        )
  ) dut_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .req_i          ( req            ),
    .we_i           ( we             ),
    .addr_i         ( addr           ),
    .be_i           ( be             ),
    .wdata_i        ( wdata          ),
    .rvalid_o       ( rvalid         ),
    .rdata_o        ( rdata          ),
    .err_o          ( err            ),
    .exit_o         ( exit_code      ),
    .exit_valid_o   ( exit_valid     ),
    .debug_enable_i ( dbg_en         ),
    .debug_req_i    ( dbg_req        ),
    .debug_req_o    ( dbg_req_gated  )
  );

  // -------------------------------------------------------------------------
  // Helpers
  // -------------------------------------------------------------------------
  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function data_t rand_word();
    data_t v;
    v[63:32] = next_rand();
    v[31:0]  = next_rand();
    return v;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail %s: expected %h, got %h", name, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // One bus cycle: check what the last cycle produced, then drive the next
  task automatic do_cycle(input logic r_req, input logic r_we, input addr_t r_addr,
                          input strb_t r_be, input data_t r_wdata);
    logic        in_rom;
    logic        in_sram;
    int unsigned idx;
    logic [31:0] r;
    @(negedge clk_i);
    cyc++;
    check_value("rvalid_o", exp_valid, rvalid);
    if (exp_valid) begin
      check_value("err_o", exp_err, err);
      if (exp_cmp) check_value("rdata_o", exp_rdata, rdata);
    end
    check_value("exit_valid_o", exp_exit_valid, exit_valid);
    check_value("exit_o", exp_exit, exit_code);
    if (cyc <= DbgDelayCycles / 2) begin
      check_value("debug_req_o", '0, dbg_req_gated);
    end else if (cyc >= 2 * DbgDelayCycles) begin
      check_value("debug_req_o", dbg_en ? dbg_req : '0, dbg_req_gated);
    end

    // Predict the response to the new request
    in_rom  = (r_addr >= RomBase) && (r_addr < RomBase + RomWords * StrbWidth);
    in_sram = (r_addr >= SramBase) && (r_addr < SramBase + NumWords * StrbWidth);
    exp_valid = r_req;
    exp_err   = 1'b0;
    exp_rdata = '0;
    exp_cmp   = 1'b1;
    if (r_req && in_sram) begin
      idx = (r_addr - SramBase) / StrbWidth;
      if (r_we) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (r_be[b]) sram_model[idx][b*8 +: 8] = r_wdata[b*8 +: 8];
        end
        if (r_be == '1) word_known[idx] = 1'b1;
        if (r_addr == ExitAddr && !exp_exit_valid) begin
          exp_exit_valid = 1'b1;
          exp_exit       = r_wdata;
        end
      end else begin
        exp_rdata = sram_model[idx];
        exp_cmp   = word_known[idx];  // Unwritten bytes are unknown
      end
    end else if (r_req && in_rom && !r_we) begin
      exp_rdata = BootImage[((r_addr - RomBase) / StrbWidth) % RomWords];
    end else if (r_req) begin
      exp_err = 1'b1;                  // Unmapped, or write to ROM
    end

    req   = r_req;
    we    = r_we;
    addr  = r_addr;
    be    = r_be;
    wdata = r_wdata;
    r       = next_rand();
    dbg_req = r[NrHarts-1:0];
    dbg_en  = (r[9:8] != 2'b00);
  endtask

  function addr_t pool_addr(input logic [4:0] sel);
    // Spread over the SRAM, never on the exit word
    return SramBase + addr_t'((int'(sel) * 32 + 1) * StrbWidth);
  endfunction

  // -------------------------------------------------------------------------
  // Stimulus
  // -------------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    addr_t       a;
    rng_state = Seed;
    rst_ni  = 1'b0;
    req     = 1'b0;
    we      = 1'b0;
    addr    = '0;
    be      = '0;
    wdata   = '0;
    dbg_en  = 1'b0;
    dbg_req = '0;
    exp_valid      = 1'b0;
    exp_err        = 1'b0;
    exp_rdata      = '0;
    exp_cmp        = 1'b0;
    exp_exit_valid = 1'b0;
    exp_exit       = '0;
    cyc            = 0;
    for (int i = 0; i < NumWords; i++) word_known[i] = 1'b0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;

    // ROM reads at random byte offsets
    for (int i = 0; i < RomReads; i++) begin
      r = next_rand();
      do_cycle(1'b1, 1'b0, RomBase + addr_t'(r[5:0]), '0, '0);
    end

    // Fill the SRAM pool, then random byte-enabled traffic
    for (int i = 0; i < PoolWords; i++) begin
      do_cycle(1'b1, 1'b1, pool_addr(5'(i)), '1, rand_word());
    end
    for (int i = 0; i < SramOps; i++) begin
      r = next_rand();
      if (r[31:29] == 3'd0) begin
        do_cycle(1'b0, 1'b0, '0, '0, '0);
      end else begin
        do_cycle(1'b1, r[28], pool_addr(r[4:0]), strb_t'(next_rand()), rand_word());
      end
    end

    // ---------------------------------------------------------------------
    // Error responses, then read back that nothing changed
    // ---------------------------------------------------------------------
    for (int i = 0; i < ErrOps; i++) begin
      r = next_rand();
      case (r[1:0])
        // Aliases a pool word one SRAM size above the region
        2'd0: a = pool_addr(r[6:2]) + addr_t'(NumWords * StrbWidth);
        2'd1: a = RomBase + addr_t'(RomWords * StrbWidth) + addr_t'(r[9:2]) * 8;
        2'd2: a = addr_t'(r[15:3]) * 8;  // Below the ROM
        default: a = RomBase + addr_t'(r[4:2]) * 8;
      endcase
      do_cycle(1'b1, (r[1:0] == 2'd3) ? 1'b1 : r[20], a, strb_t'(next_rand()),
               rand_word());
    end
    for (int i = 0; i < PoolWords; i++) begin
      do_cycle(1'b1, 1'b0, pool_addr(5'(i)), '0, '0);
    end
    for (int i = 0; i < RomWords; i++) begin
      do_cycle(1'b1, 1'b0, RomBase + addr_t'(i * StrbWidth), '0, '0);
    end

    // Exit code, only the first write counts
    do_cycle(1'b1, 1'b1, ExitAddr, '1, rand_word());
    do_cycle(1'b0, 1'b0, '0, '0, '0);
    do_cycle(1'b1, 1'b1, ExitAddr, strb_t'(next_rand()), rand_word());
    do_cycle(1'b1, 1'b0, ExitAddr, '0, '0);
    do_cycle(1'b1, 1'b1, ExitAddr, '1, rand_word());
    do_cycle(1'b1, 1'b0, ExitAddr, '0, '0);

    // Drain the last response
    do_cycle(1'b0, 1'b0, '0, '0, '0);
    do_cycle(1'b0, 1'b0, '0, '0, '0);

    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    $display("Watchdog expired before the test sequence completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "Timeout");
  end

endmodule

// ==== soc_harness.f ====
logic/harness_pkg.sv
logic/bus_demux.sv
logic/boot_rom.sv
logic/data_sram.sv
logic/exit_monitor.sv
logic/debug_req_gate.sv
logic/soc_harness.sv
dv/tb_soc_harness.sv

// ==== Bender.yml ====
package:
  name: soc_harness

sources:
  # RTL in compile order
  - logic/harness_pkg.sv
  - logic/bus_demux.sv
  - logic/boot_rom.sv
  - logic/data_sram.sv
  - logic/exit_monitor.sv
  - logic/debug_req_gate.sv
  - logic/soc_harness.sv

  # Testbench
  - target: test
    files:
      - dv/tb_soc_harness.sv
